// File: rtl/rv_pkg.sv
package rv_pkg;

    // widths with a meaning of their own
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [9:0]  imem_addr_t;
    typedef logic [9:0]  dmem_addr_t;
    typedef logic [3:0]  byte_en_t;

    localparam int IMEM_DEPTH = 1024;
    localparam int DMEM_DEPTH = 1024;

    localparam word_t       RESET_PC   = 32'h0000_0000;
    // addi x0, x0, 0
    localparam word_t       NOP_INSTR  = 32'h0000_0013;
    localparam logic [11:0] CSR_TOHOST = 12'h51E;

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic {A_REG, A_PC} a_sel_e;
    typedef enum logic {B_REG, B_IMM} b_sel_e;
    typedef enum logic [1:0] {WB_LOAD, WB_ALU, WB_PC4} wb_sel_e;
    typedef enum logic [1:0] {PC_PLUS4, PC_JAL, PC_REDIRECT} pc_sel_e;
    typedef enum logic {FWD_REG, FWD_WB} fwd_e;

    // control for the instruction in execute
    typedef struct packed {
        alu_op_e alu_op;
        a_sel_e  a_sel;
        b_sel_e  b_sel;
        logic    br_un;
        logic    is_branch;
        logic    is_jalr;
        logic    mem_write;
        logic    csr_write;
        logic    csr_imm;
    } x_ctrl_t;

    // funct3 gives the load width and sign, and the store width as well
    typedef struct packed {
        logic       rf_we;
        wb_sel_e    wb_sel;
        logic [2:0] funct3;
    } wb_ctrl_t;

endpackage

// File: rtl/reg_file.sv
`timescale 1ns/1ns

module reg_file (
    input  logic              clk,
    input  logic              we,
    input  rv_pkg::reg_addr_t ra1,
    input  rv_pkg::reg_addr_t ra2,
    input  rv_pkg::reg_addr_t wa,
    input  rv_pkg::word_t     wd,
    output rv_pkg::word_t     rd1,
    output rv_pkg::word_t     rd2
);
    import rv_pkg::*;

    // no storage behind x0
    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (we && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

    assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

endmodule

// File: rtl/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit (
    input  logic               clk,
    input  logic               reset,
    input  logic               load_we,
    input  rv_pkg::imem_addr_t load_addr,
    input  rv_pkg::word_t      load_data,
    input  rv_pkg::pc_sel_e    pc_sel,
    input  logic               squash,
    input  rv_pkg::word_t      redirect_pc,
    output rv_pkg::word_t      d_instr,
    output rv_pkg::word_t      d_pc
);
    import rv_pkg::*;

    word_t      imem [IMEM_DEPTH];
    word_t      pc_q;
    word_t      pc_plus4;
    word_t      j_imm;
    word_t      jal_target;
    word_t      fetch_addr;
    word_t      imem_q;
    imem_addr_t fetch_index;

    assign pc_plus4   = pc_q + 32'd4;
    assign j_imm      = {{12{d_instr[31]}}, d_instr[19:12], d_instr[20], d_instr[30:21], 1'b0};
    assign jal_target = pc_q + j_imm;

    // the read address never depends on the decode instruction
    // a jal loads its target into the pc and the fetch repeats from there
    always_comb begin
        if (reset) begin
            fetch_addr = RESET_PC;
        end else if (pc_sel == PC_REDIRECT) begin
            // jalr clears bit 0, branch targets are already even
            fetch_addr = {redirect_pc[31:1], 1'b0};
        end else if (squash) begin
            fetch_addr = pc_q;
        end else begin
            fetch_addr = pc_plus4;
        end
    end

    assign fetch_index = fetch_addr[11:2];

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= RESET_PC;
        end else if (pc_sel == PC_JAL) begin
            pc_q <= jal_target;
        end else begin
            pc_q <= fetch_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (load_we) begin
            imem[load_addr] <= load_data;
        end
        imem_q <= imem[fetch_index];
    end

    assign d_instr = (squash || reset) ? NOP_INSTR : imem_q;
    assign d_pc    = pc_q;

endmodule

// File: rtl/pipeline_control.sv
`timescale 1ns/1ns

module pipeline_control (
    input  logic              clk,
    input  logic              reset,
    input  rv_pkg::word_t     d_instr,
    input  rv_pkg::word_t     x_instr,
    input  logic              branch_taken,
    output rv_pkg::pc_sel_e   pc_sel,
    output logic              squash,
    output rv_pkg::x_ctrl_t   x_ctrl,
    output rv_pkg::wb_ctrl_t  wb_ctrl,
    output logic              rf_we,
    output rv_pkg::reg_addr_t rf_wa,
    output rv_pkg::fwd_e      d_fwd1,
    output rv_pkg::fwd_e      d_fwd2,
    output rv_pkg::fwd_e      x_fwd1,
    output rv_pkg::fwd_e      x_fwd2
);
    import rv_pkg::*;

    word_t    w_instr;
    wb_ctrl_t w_ctrl;
    logic     jal_q;
    logic     d_is_jal;
    logic     x_redirect;

    // alt selects sub and sra
    function automatic alu_op_e alu_decode(logic [2:0] f3, logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic x_ctrl_t decode_x(word_t instr);
        x_ctrl_t    c;
        logic [2:0] f3;
        f3          = instr[14:12];
        c.alu_op    = ALU_ADD;
        c.a_sel     = A_REG;
        c.b_sel     = B_IMM;
        c.br_un     = f3[1];
        c.is_branch = 1'b0;
        c.is_jalr   = 1'b0;
        c.mem_write = 1'b0;
        c.csr_write = 1'b0;
        c.csr_imm   = f3[2];
        case (opcode_e'(instr[6:0]))
            OP_REG: begin
                c.alu_op = alu_decode(f3, instr[30]);
                c.b_sel  = B_REG;
            end
            // bit 30 is part of the immediate except for srai
            OP_IMM:   c.alu_op = alu_decode(f3, instr[30] && f3 == 3'b101);
            OP_LUI:   c.alu_op = ALU_PASS_B;
            OP_AUIPC: c.a_sel = A_PC;
            OP_JALR:  c.is_jalr = 1'b1;
            OP_BRANCH: begin
                c.a_sel     = A_PC;
                c.is_branch = 1'b1;
            end
            OP_STORE: c.mem_write = 1'b1;
            // csrrw and csrrwi to tohost only
            OP_SYSTEM: c.csr_write = (f3[1:0] == 2'b01) && (instr[31:20] == CSR_TOHOST);
            default: ;
        endcase
        return c;
    endfunction

    function automatic wb_ctrl_t decode_wb(word_t instr);
        wb_ctrl_t c;
        c.rf_we  = 1'b0;
        c.wb_sel = WB_ALU;
        c.funct3 = instr[14:12];
        case (opcode_e'(instr[6:0]))
            OP_REG, OP_IMM, OP_LUI, OP_AUIPC: c.rf_we = 1'b1;
            OP_LOAD: begin
                c.rf_we  = 1'b1;
                c.wb_sel = WB_LOAD;
            end
            OP_JAL, OP_JALR: begin
                c.rf_we  = 1'b1;
                c.wb_sel = WB_PC4;
            end
            default: ;
        endcase
        // never set for x0, so forwarding needs no separate zero check
        c.rf_we = c.rf_we && (instr[11:7] != 5'd0);
        return c;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            w_instr <= NOP_INSTR;
            jal_q   <= 1'b0;
        end else begin
            w_instr <= x_instr;
            jal_q   <= d_is_jal;
        end
    end

    assign x_ctrl  = decode_x(x_instr);
    assign wb_ctrl = decode_wb(x_instr);
    assign w_ctrl  = decode_wb(w_instr);
    assign rf_we   = w_ctrl.rf_we;
    assign rf_wa   = w_instr[11:7];

    assign d_fwd1 = (rf_we && rf_wa == d_instr[19:15]) ? FWD_WB : FWD_REG;
    assign d_fwd2 = (rf_we && rf_wa == d_instr[24:20]) ? FWD_WB : FWD_REG;
    assign x_fwd1 = (rf_we && rf_wa == x_instr[19:15]) ? FWD_WB : FWD_REG;
    assign x_fwd2 = (rf_we && rf_wa == x_instr[24:20]) ? FWD_WB : FWD_REG;

    assign d_is_jal   = (opcode_e'(d_instr[6:0]) == OP_JAL);
    assign x_redirect = branch_taken || x_ctrl.is_jalr;
    // jal_q kills the sequential slot fetched while the jal sat in decode
    assign squash     = x_redirect || jal_q;

    always_comb begin
        if (x_redirect) begin
            pc_sel = PC_REDIRECT;
        end else if (d_is_jal) begin
            pc_sel = PC_JAL;
        end else begin
            pc_sel = PC_PLUS4;
        end
    end

endmodule

// File: rtl/execute_unit.sv
`timescale 1ns/1ns

module execute_unit (
    input  logic            clk,
    input  logic            reset,
    input  rv_pkg::word_t   d_instr,
    input  rv_pkg::word_t   d_pc,
    input  rv_pkg::word_t   rd1,
    input  rv_pkg::word_t   rd2,
    input  rv_pkg::word_t   wb_result,
    input  rv_pkg::fwd_e    d_fwd1,
    input  rv_pkg::fwd_e    d_fwd2,
    input  rv_pkg::fwd_e    x_fwd1,
    input  rv_pkg::fwd_e    x_fwd2,
    input  rv_pkg::x_ctrl_t x_ctrl,
    output rv_pkg::word_t   x_instr,
    output rv_pkg::word_t   alu_result,
    output rv_pkg::word_t   store_data,
    output rv_pkg::word_t   x_pc,
    output logic            branch_taken,
    output rv_pkg::word_t   tohost,
    output logic            tohost_we
);
    import rv_pkg::*;

    word_t      rs1_q;
    word_t      rs2_q;
    word_t      op1;
    word_t      op2;
    word_t      imm;
    word_t      alu_a;
    word_t      alu_b;
    logic [4:0] shamt;
    logic [2:0] funct3;
    logic       br_eq;
    logic       br_lt;

    always_ff @(posedge clk) begin
        if (reset) begin
            x_instr <= NOP_INSTR;
        end else begin
            x_instr <= d_instr;
        end
    end

    // operands leaving decode already see the writeback result
    always_ff @(posedge clk) begin
        x_pc  <= d_pc;
        rs1_q <= (d_fwd1 == FWD_WB) ? wb_result : rd1;
        rs2_q <= (d_fwd2 == FWD_WB) ? wb_result : rd2;
    end

    assign op1 = (x_fwd1 == FWD_WB) ? wb_result : rs1_q;
    assign op2 = (x_fwd2 == FWD_WB) ? wb_result : rs2_q;

    always_comb begin
        case (opcode_e'(x_instr[6:0]))
            OP_STORE: imm = {{20{x_instr[31]}}, x_instr[31:25], x_instr[11:7]};
            OP_BRANCH: imm = {{19{x_instr[31]}}, x_instr[31], x_instr[7],
                              x_instr[30:25], x_instr[11:8], 1'b0};
            OP_LUI, OP_AUIPC: imm = {x_instr[31:12], 12'b0};
            default: imm = {{20{x_instr[31]}}, x_instr[31:20]};
        endcase
    end

    // funct3[2] picks less-than over equal, funct3[0] inverts
    assign funct3       = x_instr[14:12];
    assign br_eq        = (op1 == op2);
    assign br_lt        = x_ctrl.br_un ? (op1 < op2) : ($signed(op1) < $signed(op2));
    assign branch_taken = x_ctrl.is_branch && (funct3[2] ? (br_lt ^ funct3[0])
                                                         : (br_eq ^ funct3[0]));

    assign alu_a = (x_ctrl.a_sel == A_PC) ? x_pc : op1;
    assign alu_b = (x_ctrl.b_sel == B_IMM) ? imm : op2;
    assign shamt = alu_b[4:0];

    always_comb begin
        case (x_ctrl.alu_op)
            ALU_SUB:    alu_result = alu_a - alu_b;
            ALU_SLL:    alu_result = alu_a << shamt;
            ALU_SLT:    alu_result = {31'b0, $signed(alu_a) < $signed(alu_b)};
            ALU_SLTU:   alu_result = {31'b0, alu_a < alu_b};
            ALU_XOR:    alu_result = alu_a ^ alu_b;
            ALU_SRL:    alu_result = alu_a >> shamt;
            ALU_SRA:    alu_result = word_t'($signed(alu_a) >>> shamt);
            ALU_OR:     alu_result = alu_a | alu_b;
            ALU_AND:    alu_result = alu_a & alu_b;
            ALU_PASS_B: alu_result = alu_b;
            default:    alu_result = alu_a + alu_b;
        endcase
    end

    assign store_data = op2;

    // csrrwi takes the zero-extended rs1 field as data
    always_ff @(posedge clk) begin
        if (reset) begin
            tohost    <= '0;
            tohost_we <= 1'b0;
        end else begin
            tohost_we <= x_ctrl.csr_write;
            if (x_ctrl.csr_write) begin
                tohost <= x_ctrl.csr_imm ? {27'b0, x_instr[19:15]} : op1;
            end
        end
    end

endmodule

// File: rtl/mem_writeback.sv
`timescale 1ns/1ns

module mem_writeback (
    input  logic             clk,
    input  logic             reset,
    input  rv_pkg::word_t    alu_result,
    input  rv_pkg::word_t    store_data,
    input  rv_pkg::word_t    x_pc,
    input  rv_pkg::x_ctrl_t  x_ctrl,
    input  rv_pkg::wb_ctrl_t wb_ctrl,
    output rv_pkg::word_t    wb_result
);
    import rv_pkg::*;

    word_t      dmem [DMEM_DEPTH];
    dmem_addr_t dmem_addr;
    byte_en_t   byte_en;
    word_t      wdata;
    word_t      rdata_q;
    word_t      alu_q;
    word_t      pc4_q;
    wb_ctrl_t   wb_q;
    word_t      lane;
    word_t      load_data;

    assign dmem_addr = alu_result[11:2];
    // data moves up into its byte lane
    assign wdata     = store_data << {alu_result[1:0], 3'b000};

    // lanes shifted past the top of the word are dropped
    always_comb begin
        byte_en = '0;
        if (x_ctrl.mem_write) begin
            case (wb_ctrl.funct3[1:0])
                2'b00:   byte_en = 4'b0001 << alu_result[1:0];
                2'b01:   byte_en = 4'b0011 << alu_result[1:0];
                default: byte_en = 4'b1111 << alu_result[1:0];
            endcase
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (byte_en[i]) begin
                dmem[dmem_addr][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
        rdata_q <= dmem[dmem_addr];
    end

    always_ff @(posedge clk) begin
        alu_q <= alu_result;
        pc4_q <= x_pc + 32'd4;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_q <= '0;
        end else begin
            wb_q <= wb_ctrl;
        end
    end

    // addressed byte or half down to bit 0
    assign lane = rdata_q >> {alu_q[1:0], 3'b000};

    always_comb begin
        case (wb_q.funct3)
            3'b000:  load_data = {{24{lane[7]}}, lane[7:0]};
            3'b001:  load_data = {{16{lane[15]}}, lane[15:0]};
            3'b100:  load_data = {24'b0, lane[7:0]};
            3'b101:  load_data = {16'b0, lane[15:0]};
            default: load_data = lane;
        endcase
    end

    always_comb begin
        case (wb_q.wb_sel)
            WB_LOAD: wb_result = load_data;
            WB_PC4:  wb_result = pc4_q;
            default: wb_result = alu_q;
        endcase
    end

endmodule

// File: rtl/rv_core.sv
`timescale 1ns/1ns

module rv_core (
    input  logic               clk,
    input  logic               reset,
    input  logic               load_we,
    input  rv_pkg::imem_addr_t load_addr,
    input  rv_pkg::word_t      load_data,
    output rv_pkg::word_t      tohost,
    output logic               tohost_we
);
    import rv_pkg::*;

    word_t     d_instr;
    word_t     d_pc;
    word_t     x_instr;
    word_t     x_pc;
    word_t     alu_result;
    word_t     store_data;
    word_t     wb_result;
    word_t     rd1;
    word_t     rd2;
    logic      branch_taken;
    pc_sel_e   pc_sel;
    logic      squash;
    x_ctrl_t   x_ctrl;
    wb_ctrl_t  wb_ctrl;
    logic      rf_we;
    reg_addr_t rf_wa;
    fwd_e      d_fwd1;
    fwd_e      d_fwd2;
    fwd_e      x_fwd1;
    fwd_e      x_fwd2;

    pipeline_control u_control (
        .clk          (clk),
        .reset        (reset),
        .d_instr      (d_instr),
        .x_instr      (x_instr),
        .branch_taken (branch_taken),
        .pc_sel       (pc_sel),
        .squash       (squash),
        .x_ctrl       (x_ctrl),
        .wb_ctrl      (wb_ctrl),
        .rf_we        (rf_we),
        .rf_wa        (rf_wa),
        .d_fwd1       (d_fwd1),
        .d_fwd2       (d_fwd2),
        .x_fwd1       (x_fwd1),
        .x_fwd2       (x_fwd2)
    );

    // branch and jalr targets come straight from the alu
    fetch_unit u_fetch (
        .clk         (clk),
        .reset       (reset),
        .load_we     (load_we),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .pc_sel      (pc_sel),
        .squash      (squash),
        .redirect_pc (alu_result),
        .d_instr     (d_instr),
        .d_pc        (d_pc)
    );

    reg_file u_regs (
        .clk (clk),
        .we  (rf_we),
        .ra1 (d_instr[19:15]),
        .ra2 (d_instr[24:20]),
        .wa  (rf_wa),
        .wd  (wb_result),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    execute_unit u_execute (
        .clk          (clk),
        .reset        (reset),
        .d_instr      (d_instr),
        .d_pc         (d_pc),
        .rd1          (rd1),
        .rd2          (rd2),
        .wb_result    (wb_result),
        .d_fwd1       (d_fwd1),
        .d_fwd2       (d_fwd2),
        .x_fwd1       (x_fwd1),
        .x_fwd2       (x_fwd2),
        .x_ctrl       (x_ctrl),
        .x_instr      (x_instr),
        .alu_result   (alu_result),
        .store_data   (store_data),
        .x_pc         (x_pc),
        .branch_taken (branch_taken),
        .tohost       (tohost),
        .tohost_we    (tohost_we)
    );

    mem_writeback u_mem_wb (
        .clk        (clk),
        .reset      (reset),
        .alu_result (alu_result),
        .store_data (store_data),
        .x_pc       (x_pc),
        .x_ctrl     (x_ctrl),
        .wb_ctrl    (wb_ctrl),
        .wb_result  (wb_result)
    );

endmodule

// File: verification/tb_rv_core.sv
`timescale 1ns/1ns

module tb_rv_core;
    import rv_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int DATA_WORDS = 1024;
    // settle cycles after the expected count is reached
    localparam int TAIL_CYCLES = 20;

    logic       clk;
    logic       reset;
    logic       load_we;
    imem_addr_t load_addr;
    word_t      load_data;
    word_t      tohost;
    logic       tohost_we;

    word_t test_data [0:DATA_WORDS-1];
    int    limit_cycles;
    int    ptr;
    int    num_words;
    int    num_tests;
    int    writes;
    word_t last_tohost;
    word_t exp_tohost;
    int    exp_writes;

    rv_core DUT (
        .clk       (clk),
        .reset     (reset),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .tohost    (tohost),
        .tohost_we (tohost_we)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got !== exp) begin
            $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    // program goes in while reset is held
    task automatic load_program(input int start, input int count);
        @(posedge clk);
        reset <= 1'b1;
        for (int i = 0; i < count; i++) begin
            @(posedge clk);
            load_we   <= 1'b1;
            load_addr <= imem_addr_t'(i);
            load_data <= test_data[start + i];
        end
        @(posedge clk);
        load_we <= 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    endtask

    // tohost is stable at the falling edge of a pulse
    task automatic collect_writes(input int expected);
        writes = 0;
        while (writes < expected) begin
            @(negedge clk);
            if (tohost_we) begin
                writes++;
                last_tohost = tohost;
            end
        end
        repeat (TAIL_CYCLES) begin
            @(negedge clk);
            if (tohost_we) begin
                writes++;
            end
        end
    endtask

    // watchdog budget from the program sizes in the test file
    initial begin
        wait (limit_cycles > 0);
        #(limit_cycles * CLK_PERIOD);
        $display("timeout: tohost was not written the expected number of times");
        $display("TEST RESULT: FAIL");
        $fatal(1);
    end

    initial begin
        int p;
        int n;
        reset        = 1'b1;
        load_we      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        num_tests    = 0;
        limit_cycles = 0;
        $readmemh("verification/rv_core_tests.txt", test_data);

        p = 0;
        n = 0;
        while (p < DATA_WORDS && test_data[p] !== 32'h0 && test_data[p] !== 'x) begin
            n = n + 200 * test_data[p] + test_data[p] + 10 + TAIL_CYCLES;
            p = p + test_data[p] + 3;
        end
        limit_cycles = n + 10;

        ptr = 0;
        while (ptr < DATA_WORDS && test_data[ptr] !== 32'h0 && test_data[ptr] !== 'x) begin
            num_words  = test_data[ptr];
            exp_tohost = test_data[ptr + num_words + 1];
            exp_writes = test_data[ptr + num_words + 2];
            load_program(ptr + 1, num_words);
            collect_writes(exp_writes);
            check_count("tohost write count", writes, exp_writes);
            check_word("tohost", last_tohost, exp_tohost);
            num_tests++;
            ptr = ptr + num_words + 3;
        end

        $display("ran %0d programs", num_tests);
        if (num_tests > 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("no programs were run");
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: verification/rv_core_tests.txt
// per program: word count, program words, expected tohost, expected tohost writes
// a word count of zero ends the list
// arithmetic, shifts, srai of a negative value, slt against sltu
0000000C
FF800093 4010D113 01C0D193 0030B233 0030A2B3 00821213
00429293 00314333 00436333 40530333 51E31073 0000006F
FFFFFFE3 00000001
// lui and auipc
00000005
123450B7 00001117 002081B3 51E19073 0000006F
12346004 00000001
// six branches taken then untaken, wrong path adds 64 or writes tohost
0000001D
FFF00093 00100113 00000513
00210463 51EFD073
00209463 04050513
0020C463 04050513
00115463 04050513
00116463 04050513
0020F463 04050513
00208463 00150513
00211463 00150513
00114463 00150513
0020D463 00150513
0020E463 00150513
00117463 00150513
51E51073 0000006F
00000006 00000001
// jal and jalr link values, jalr to an odd target
00000008
00C000EF 51EFD073 00100313 00D08167 00811193 001181B3 51E19073 0000006F
00001004 00000001
// byte, half and word stores then all loads, load followed by use
0000001C
89ABD137 DEF10113 10000093 0020A023
08100193 0030A223 0020A2A3 0030A323 0000A3A3
00209423 00309523
00408203 0050C283 00809303 00A0D383 0000A403 00308483
00848533 00750533 00650533 00550533 00450533
0040A603 00C54533 0080A683 00D54533
51E51073 0000006F
89ABBE36 00000001
// csrrwi and csrrw with back to back dependencies
00000008
00500093 51E3D073 00308093 51E09073 00108133 00210133 51E11073 0000006F
00000020 00000003
00000000

// File: src.f
rtl/rv_pkg.sv
rtl/reg_file.sv
rtl/fetch_unit.sv
rtl/pipeline_control.sv
rtl/execute_unit.sv
rtl/mem_writeback.sv
rtl/rv_core.sv
verification/tb_rv_core.sv
